// ==== source/glb_pkg.sv ====
// Geometry and vector types for the global buffer
// Imported by every module of the buffer and by its testbench

package glb_pkg;

    // ==============================
    // Buffer geometry
    // ==============================
    localparam int NUM_BANK   = 8;
    localparam int NUM_WRPORT = 2;
    localparam int NUM_RDPORT = 2;
    localparam int MAXPAR     = 4;
    localparam int BANK_WORDS = 16;
    localparam int BANK_WIDTH = 16;
    localparam int ADDR_WIDTH = 8;

    // ==============================
    // Vector types
    // ==============================

    // One word of one SRAM bank
    typedef logic [BANK_WIDTH-1:0] bank_data_t;

    // MAXPAR lanes side by side, lane k at bits BANK_WIDTH*k and up
    typedef logic [MAXPAR*BANK_WIDTH-1:0] port_data_t;

    // Word address inside a bank
    typedef logic [$clog2(BANK_WORDS)-1:0] bank_addr_t;

    // Stream address as seen by a port
    typedef logic [ADDR_WIDTH-1:0] port_addr_t;

    // One bit per bank
    typedef logic [NUM_BANK-1:0] bank_mask_t;
    typedef logic [$clog2(NUM_BANK)-1:0] bank_idx_t;

    // Parallelism 1..MAXPAR, needs one bit above the log
    typedef logic [$clog2(MAXPAR):0] par_t;

    // Port indices for bank ownership
    typedef logic [$clog2(NUM_WRPORT)-1:0] wr_idx_t;
    typedef logic [$clog2(NUM_RDPORT)-1:0] rd_idx_t;

endpackage

// ==== source/glb_bank.sv ====
// Single-port SRAM bank with a write strobe and a handshaked, registered read
// Read data is held in the output register until the consumer takes it

`timescale 1ns/1ns

module glb_bank
    import glb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en_i,
    input  bank_addr_t wr_addr_i,
    input  bank_data_t wr_data_i,
    input  logic       rd_en_i,
    input  bank_addr_t rd_addr_i,
    input  logic       rd_ready_i,
    output logic       rd_addr_rdy_o,
    output logic       rd_valid_o,
    output bank_data_t rd_data_o
);

    bank_data_t mem [BANK_WORDS];
    bank_data_t rd_data_q;
    logic       rd_valid_q;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Output register, loaded on an accepted address
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else if (rd_en_i) begin
            rd_valid_q <= 1'b1;
        end else if (rd_ready_i) begin
            rd_valid_q <= 1'b0;
        end
    end

    // Free slot, or the held word leaves this cycle
    assign rd_addr_rdy_o = !rd_valid_q || rd_ready_i;
    assign rd_valid_o    = rd_valid_q;
    assign rd_data_o     = rd_data_q;

    // Upstream control must respect the bank's slot
    a_rd_en_when_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en_i |-> rd_addr_rdy_o
    );

    a_hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid_q && !rd_ready_i |=> rd_valid_q && $stable(rd_data_q)
    );

endmodule

// ==== source/glb_port_map.sv ====
// Address mapping of one port onto its group of adjacent banks
// Purely combinational, one instance per write and per read port

`timescale 1ns/1ns

module glb_port_map
    import glb_pkg::*;
(
    input  port_addr_t addr_i,
    input  bank_mask_t mask_i,
    input  par_t       par_i,
    output logic       alloc_o,
    output port_addr_t range_o,
    output bank_idx_t  first_bank_o,
    output bank_mask_t hit_o,
    output bank_addr_t bank_addr_o
);

    always_comb begin
        int num;
        int low;
        int par;
        int rng;
        int grp;
        int first;

        // Popcount and lowest set bit in one pass, scanning downwards
        num = 0;
        low = 0;
        for (int b = NUM_BANK - 1; b >= 0; b--) begin
            if (mask_i[b]) begin
                num = num + 1;
                low = b;
            end
        end

        // A zero parallelism would be a broken config, treat as one lane
        par = (par_i == '0) ? 1 : int'(par_i);
        rng = (num * BANK_WORDS) / par;

        // Which group of par banks the address falls into
        grp   = (rng == 0) ? 0 : (int'(addr_i) % rng) / BANK_WORDS;
        first = low + par * grp;

        alloc_o      = (num != 0);
        range_o      = port_addr_t'(rng);
        first_bank_o = bank_idx_t'(first);

        for (int b = 0; b < NUM_BANK; b++) begin
            hit_o[b] = alloc_o && (b >= first) && (b < first + par);
        end
    end

    assign bank_addr_o = bank_addr_t'(addr_i % BANK_WORDS);

endmodule

// ==== source/glb_ctrl.sv ====
// Central control of the buffer: bank owners, progress pointers per bank,
// full/empty flags, port ready signals and the bank enables

`timescale 1ns/1ns

module glb_ctrl
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  bank_mask_t            cfg_wr_mask_i [NUM_WRPORT],
    input  bank_mask_t            cfg_rd_mask_i [NUM_RDPORT],

    // Write ports
    input  logic [NUM_WRPORT-1:0] wr_vld_i,
    input  port_addr_t            wr_addr_i [NUM_WRPORT],
    input  logic [NUM_WRPORT-1:0] wr_alloc_i,
    input  port_addr_t            wr_range_i [NUM_WRPORT],
    input  bank_idx_t             wr_first_i [NUM_WRPORT],
    input  bank_mask_t            wr_hit_i [NUM_WRPORT],
    output logic [NUM_WRPORT-1:0] wr_rdy_o,
    output logic [NUM_WRPORT-1:0] wr_full_o,

    // Read ports
    input  logic [NUM_RDPORT-1:0] rd_addr_vld_i,
    input  port_addr_t            rd_addr_i [NUM_RDPORT],
    input  logic [NUM_RDPORT-1:0] rd_alloc_i,
    input  bank_idx_t             rd_first_i [NUM_RDPORT],
    input  bank_mask_t            rd_hit_i [NUM_RDPORT],
    output logic [NUM_RDPORT-1:0] rd_addr_rdy_o,

    // Banks
    input  logic [NUM_BANK-1:0]   bank_rd_addr_rdy_i,
    output logic [NUM_BANK-1:0]   bank_wr_en_o,
    output logic [NUM_BANK-1:0]   bank_rd_en_o,
    output wr_idx_t               bank_wr_owner_o [NUM_BANK],
    output rd_idx_t               bank_rd_owner_o [NUM_BANK]
);

    port_addr_t            wr_next_q [NUM_BANK];
    port_addr_t            rd_next_q [NUM_BANK];
    logic [NUM_WRPORT-1:0] wr_acc;
    logic [NUM_RDPORT-1:0] rd_acc;

    // ==============================
    // Bank ownership
    // ==============================

    // Scan from the top so the lowest matching port wins
    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            bank_wr_owner_o[b] = '0;
            for (int j = NUM_WRPORT - 1; j >= 0; j--) begin
                if (cfg_wr_mask_i[j][b]) begin
                    bank_wr_owner_o[b] = wr_idx_t'(j);
                end
            end
            bank_rd_owner_o[b] = '0;
            for (int i = NUM_RDPORT - 1; i >= 0; i--) begin
                if (cfg_rd_mask_i[i][b]) begin
                    bank_rd_owner_o[b] = rd_idx_t'(i);
                end
            end
        end
    end

    // ==============================
    // Port flags and handshakes
    // ==============================
    for (genvar j = 0; j < NUM_WRPORT; j++) begin : g_wr
        port_addr_t wr_dist;

        // Words written but not yet read back on this group
        assign wr_dist      = wr_addr_i[j] - rd_next_q[wr_first_i[j]];
        assign wr_full_o[j] = wr_alloc_i[j] && (wr_dist >= wr_range_i[j]);
        // Back off while a read takes the same bank
        assign wr_rdy_o[j]  = wr_alloc_i[j] && !wr_full_o[j]
                              && !bank_rd_en_o[wr_first_i[j]];
        assign wr_acc[j]    = wr_vld_i[j] && wr_rdy_o[j];
    end

    for (genvar i = 0; i < NUM_RDPORT; i++) begin : g_rd
        logic rd_empty;

        assign rd_empty         = rd_addr_i[i] >= wr_next_q[rd_first_i[i]];
        assign rd_addr_rdy_o[i] = rd_alloc_i[i] && !rd_empty
                                  && bank_rd_addr_rdy_i[rd_first_i[i]];
        assign rd_acc[i]        = rd_addr_vld_i[i] && rd_addr_rdy_o[i];
    end

    // Only the owner of a bank may enable it
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_en
        assign bank_wr_en_o[b] = wr_acc[bank_wr_owner_o[b]]
                                 && wr_hit_i[bank_wr_owner_o[b]][b];
        assign bank_rd_en_o[b] = rd_acc[bank_rd_owner_o[b]]
                                 && rd_hit_i[bank_rd_owner_o[b]][b];
    end

    // ==============================
    // Progress pointers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANK; b++) begin
                wr_next_q[b] <= '0;
                rd_next_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANK; b++) begin
                if (bank_wr_en_o[b]) begin
                    wr_next_q[b] <= wr_addr_i[bank_wr_owner_o[b]] + 1'b1;
                end
                if (bank_rd_en_o[b]) begin
                    rd_next_q[b] <= rd_addr_i[bank_rd_owner_o[b]] + 1'b1;
                end
            end
        end
    end

    // Single-port banks, relies on matching write and read groups
    a_no_bank_collision: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bank_wr_en_o & bank_rd_en_o) == '0
    );

endmodule

// ==== source/glb_wr_route.sv ====
// Write datapath routing: each bank takes its lane and word address
// from the write port that owns it

`timescale 1ns/1ns

module glb_wr_route
    import glb_pkg::*;
(
    input  port_data_t wr_dat_i [NUM_WRPORT],
    input  bank_idx_t  wr_first_i [NUM_WRPORT],
    input  bank_addr_t wr_bank_addr_i [NUM_WRPORT],
    input  wr_idx_t    bank_wr_owner_i [NUM_BANK],
    output bank_data_t bank_wdata_o [NUM_BANK],
    output bank_addr_t bank_waddr_o [NUM_BANK]
);

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        bank_idx_t                   lane_off;
        logic [$clog2(MAXPAR)-1:0]   lane;

        // Position of this bank inside the owner's current group
        assign lane_off = bank_idx_t'(b) - wr_first_i[bank_wr_owner_i[b]];
        // Only meaningful while the bank is hit, then it is below MAXPAR
        assign lane     = lane_off[$clog2(MAXPAR)-1:0];

        assign bank_wdata_o[b] =
            wr_dat_i[bank_wr_owner_i[b]][lane*BANK_WIDTH +: BANK_WIDTH];
        assign bank_waddr_o[b] = wr_bank_addr_i[bank_wr_owner_i[b]];
    end

endmodule

// ==== source/glb_rd_gather.sv ====
// Read datapath: assembles each read port's lanes from its bank group
// and returns the consumer's ready to the banks that port owns

`timescale 1ns/1ns

module glb_rd_gather
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_RDPORT-1:0] rd_addr_vld_i,
    input  logic [NUM_RDPORT-1:0] rd_addr_rdy_i,
    input  bank_idx_t             rd_first_i [NUM_RDPORT],
    input  logic [NUM_RDPORT-1:0] rd_dat_rdy_i,
    input  logic [NUM_BANK-1:0]   bank_rd_valid_i,
    input  bank_data_t            bank_rd_data_i [NUM_BANK],
    input  rd_idx_t               bank_rd_owner_i [NUM_BANK],
    output port_data_t            rd_dat_o [NUM_RDPORT],
    output logic [NUM_RDPORT-1:0] rd_dat_vld_o,
    output logic [NUM_BANK-1:0]   bank_rd_ready_o
);

    bank_idx_t first_q [NUM_RDPORT];

    for (genvar i = 0; i < NUM_RDPORT; i++) begin : g_port
        // Group of the word now in flight
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                first_q[i] <= '0;
            end else if (rd_addr_vld_i[i] && rd_addr_rdy_i[i]) begin
                first_q[i] <= rd_first_i[i];
            end
        end

        // Owner check keeps another port's bank from leaking in after reset
        assign rd_dat_vld_o[i] = bank_rd_valid_i[first_q[i]]
                                 && (bank_rd_owner_i[first_q[i]] == rd_idx_t'(i));

        for (genvar k = 0; k < MAXPAR; k++) begin : g_lane
            bank_idx_t lane_bank;

            assign lane_bank = first_q[i] + bank_idx_t'(k);
            assign rd_dat_o[i][k*BANK_WIDTH +: BANK_WIDTH] = bank_rd_data_i[lane_bank];
        end
    end

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        assign bank_rd_ready_o[b] = rd_dat_rdy_i[bank_rd_owner_i[b]];
    end

endmodule

// ==== source/glb_top.sv ====
// Top level of the global buffer with two write and two read stream ports
// Configuration inputs must stay stable while traffic flows

`timescale 1ns/1ns

module glb_top
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  bank_mask_t            cfg_wr_mask_i [NUM_WRPORT],
    input  par_t                  cfg_wr_par_i [NUM_WRPORT],
    input  bank_mask_t            cfg_rd_mask_i [NUM_RDPORT],
    input  par_t                  cfg_rd_par_i [NUM_RDPORT],

    input  port_data_t            wr_dat_i [NUM_WRPORT],
    input  port_addr_t            wr_addr_i [NUM_WRPORT],
    input  logic [NUM_WRPORT-1:0] wr_vld_i,
    output logic [NUM_WRPORT-1:0] wr_rdy_o,
    output logic [NUM_WRPORT-1:0] wr_full_o,

    input  port_addr_t            rd_addr_i [NUM_RDPORT],
    input  logic [NUM_RDPORT-1:0] rd_addr_vld_i,
    output logic [NUM_RDPORT-1:0] rd_addr_rdy_o,
    output port_data_t            rd_dat_o [NUM_RDPORT],
    output logic [NUM_RDPORT-1:0] rd_dat_vld_o,
    input  logic [NUM_RDPORT-1:0] rd_dat_rdy_i
);

    logic [NUM_WRPORT-1:0] wr_alloc;
    port_addr_t            wr_range [NUM_WRPORT];
    bank_idx_t             wr_first [NUM_WRPORT];
    bank_mask_t            wr_hit [NUM_WRPORT];
    bank_addr_t            wr_bank_addr [NUM_WRPORT];

    logic [NUM_RDPORT-1:0] rd_alloc;
    bank_idx_t             rd_first [NUM_RDPORT];
    bank_mask_t            rd_hit [NUM_RDPORT];
    bank_addr_t            rd_bank_addr [NUM_RDPORT];

    logic [NUM_BANK-1:0]   bank_wr_en;
    logic [NUM_BANK-1:0]   bank_rd_en;
    logic [NUM_BANK-1:0]   bank_rd_addr_rdy;
    logic [NUM_BANK-1:0]   bank_rd_valid;
    logic [NUM_BANK-1:0]   bank_rd_ready;
    wr_idx_t               bank_wr_owner [NUM_BANK];
    rd_idx_t               bank_rd_owner [NUM_BANK];
    bank_data_t            bank_wdata [NUM_BANK];
    bank_addr_t            bank_waddr [NUM_BANK];
    bank_data_t            bank_rdata [NUM_BANK];

    // ==============================
    // Address mapping per port
    // ==============================
    for (genvar j = 0; j < NUM_WRPORT; j++) begin : g_wr_map
        glb_port_map i_wr_map (
            .addr_i       (wr_addr_i[j]),
            .mask_i       (cfg_wr_mask_i[j]),
            .par_i        (cfg_wr_par_i[j]),
            .alloc_o      (wr_alloc[j]),
            .range_o      (wr_range[j]),
            .first_bank_o (wr_first[j]),
            .hit_o        (wr_hit[j]),
            .bank_addr_o  (wr_bank_addr[j])
        );
    end

    // Read side needs no range, emptiness comes from the pointers
    for (genvar i = 0; i < NUM_RDPORT; i++) begin : g_rd_map
        glb_port_map i_rd_map (
            .addr_i       (rd_addr_i[i]),
            .mask_i       (cfg_rd_mask_i[i]),
            .par_i        (cfg_rd_par_i[i]),
            .alloc_o      (rd_alloc[i]),
            .range_o      (),
            .first_bank_o (rd_first[i]),
            .hit_o        (rd_hit[i]),
            .bank_addr_o  (rd_bank_addr[i])
        );
    end

    glb_ctrl i_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .cfg_wr_mask_i      (cfg_wr_mask_i),
        .cfg_rd_mask_i      (cfg_rd_mask_i),
        .wr_vld_i           (wr_vld_i),
        .wr_addr_i          (wr_addr_i),
        .wr_alloc_i         (wr_alloc),
        .wr_range_i         (wr_range),
        .wr_first_i         (wr_first),
        .wr_hit_i           (wr_hit),
        .wr_rdy_o           (wr_rdy_o),
        .wr_full_o          (wr_full_o),
        .rd_addr_vld_i      (rd_addr_vld_i),
        .rd_addr_i          (rd_addr_i),
        .rd_alloc_i         (rd_alloc),
        .rd_first_i         (rd_first),
        .rd_hit_i           (rd_hit),
        .rd_addr_rdy_o      (rd_addr_rdy_o),
        .bank_rd_addr_rdy_i (bank_rd_addr_rdy),
        .bank_wr_en_o       (bank_wr_en),
        .bank_rd_en_o       (bank_rd_en),
        .bank_wr_owner_o    (bank_wr_owner),
        .bank_rd_owner_o    (bank_rd_owner)
    );

    glb_wr_route i_wr_route (
        .wr_dat_i        (wr_dat_i),
        .wr_first_i      (wr_first),
        .wr_bank_addr_i  (wr_bank_addr),
        .bank_wr_owner_i (bank_wr_owner),
        .bank_wdata_o    (bank_wdata),
        .bank_waddr_o    (bank_waddr)
    );

    glb_rd_gather i_rd_gather (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_addr_vld_i   (rd_addr_vld_i),
        .rd_addr_rdy_i   (rd_addr_rdy_o),
        .rd_first_i      (rd_first),
        .rd_dat_rdy_i    (rd_dat_rdy_i),
        .bank_rd_valid_i (bank_rd_valid),
        .bank_rd_data_i  (bank_rdata),
        .bank_rd_owner_i (bank_rd_owner),
        .rd_dat_o        (rd_dat_o),
        .rd_dat_vld_o    (rd_dat_vld_o),
        .bank_rd_ready_o (bank_rd_ready)
    );

    // ==============================
    // SRAM banks
    // ==============================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        glb_bank i_bank (
            .clk           (clk),
            .rst_n         (rst_n),
            .wr_en_i       (bank_wr_en[b]),
            .wr_addr_i     (bank_waddr[b]),
            .wr_data_i     (bank_wdata[b]),
            .rd_en_i       (bank_rd_en[b]),
            .rd_addr_i     (rd_bank_addr[bank_rd_owner[b]]),
            .rd_ready_i    (bank_rd_ready[b]),
            .rd_addr_rdy_o (bank_rd_addr_rdy[b]),
            .rd_valid_o    (bank_rd_valid[b]),
            .rd_data_o     (bank_rdata[b])
        );
    end

endmodule

// ==== tests/glb_tb.sv ====
// Testbench for the global buffer: streams words through both port pairs
// and checks data, latency, flow control and back-pressure with assertions

`timescale 1ns/1ns

module glb_tb
    import glb_pkg::*;
();

    localparam int RESET_CYCLES   = 16;
    // Traffic needs a few hundred cycles, the limit leaves ample margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk;
    logic                  rst_n;
    bank_mask_t            cfg_wr_mask [NUM_WRPORT];
    par_t                  cfg_wr_par [NUM_WRPORT];
    bank_mask_t            cfg_rd_mask [NUM_RDPORT];
    par_t                  cfg_rd_par [NUM_RDPORT];
    port_data_t            wr_dat [NUM_WRPORT];
    port_addr_t            wr_addr [NUM_WRPORT];
    logic [NUM_WRPORT-1:0] wr_vld;
    logic [NUM_WRPORT-1:0] wr_rdy;
    logic [NUM_WRPORT-1:0] wr_full;
    port_addr_t            rd_addr [NUM_RDPORT];
    logic [NUM_RDPORT-1:0] rd_addr_vld;
    logic [NUM_RDPORT-1:0] rd_addr_rdy;
    port_data_t            rd_dat [NUM_RDPORT];
    logic [NUM_RDPORT-1:0] rd_dat_vld;
    logic [NUM_RDPORT-1:0] rd_dat_rdy;

    // ==============================
    // Reference model state
    // ==============================
    port_data_t sb [NUM_WRPORT][2**ADDR_WIDTH];
    port_data_t keep [NUM_RDPORT];
    port_data_t exp_q [NUM_RDPORT][$];
    port_data_t exp_head [NUM_RDPORT];
    int         exp_cnt [NUM_RDPORT];

    // Phase flags, set by the stimulus while a condition must hold
    logic  chk_idle;
    logic  chk_unalloc;
    logic  chk_full;
    logic  chk_not_full;
    logic  chk_empty;
    string test_name;
    int    errors = 0;
    int    reads_checked = 0;
    int    cycles = 0;

    glb_top i_glb_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_wr_mask_i (cfg_wr_mask),
        .cfg_wr_par_i  (cfg_wr_par),
        .cfg_rd_mask_i (cfg_rd_mask),
        .cfg_rd_par_i  (cfg_rd_par),
        .wr_dat_i      (wr_dat),
        .wr_addr_i     (wr_addr),
        .wr_vld_i      (wr_vld),
        .wr_rdy_o      (wr_rdy),
        .wr_full_o     (wr_full),
        .rd_addr_i     (rd_addr),
        .rd_addr_vld_i (rd_addr_vld),
        .rd_addr_rdy_o (rd_addr_rdy),
        .rd_dat_o      (rd_dat),
        .rd_dat_vld_o  (rd_dat_vld),
        .rd_dat_rdy_i  (rd_dat_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Lanes that carry data for a given parallelism
    function automatic port_data_t lane_mask(input par_t par);
        port_data_t m;
        m = '0;
        for (int k = 0; k < int'(par); k++) begin
            m[k*BANK_WIDTH +: BANK_WIDTH] = '1;
        end
        return m;
    endfunction

    // All stimulus tasks start and end 1 ns after a rising edge
    task automatic write_word(input int p, input port_addr_t a);
        port_data_t d;
        d = {$urandom, $urandom};
        wr_addr[p] = a;
        wr_dat[p]  = d;
        wr_vld[p]  = 1'b1;
        @(posedge clk);
        while (!wr_rdy[p]) @(posedge clk);
        sb[p][a] = d & keep[p];
        #1;
        wr_vld[p] = 1'b0;
    endtask

    task automatic write_stream(input int p, input int first, input int count);
        for (int n = 0; n < count; n++) begin
            write_word(p, port_addr_t'(first + n));
        end
    endtask

    task automatic request_read(input int p, input port_addr_t a);
        rd_addr[p]     = a;
        rd_addr_vld[p] = 1'b1;
        @(posedge clk);
        while (!rd_addr_rdy[p]) @(posedge clk);
        #1;
        rd_addr_vld[p] = 1'b0;
    endtask

    task automatic read_stream(input int p, input int first, input int count);
        for (int n = 0; n < count; n++) begin
            request_read(p, port_addr_t'(first + n));
        end
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
            #1;
        end while (exp_cnt[0] != 0 || exp_cnt[1] != 0);
    endtask

    // Expected read data in order of address acceptance
    always @(posedge clk) begin : model
        for (int i = 0; i < NUM_RDPORT; i++) begin
            if (rd_dat_vld[i] && rd_dat_rdy[i] && exp_q[i].size() > 0) begin
                void'(exp_q[i].pop_front());
                reads_checked++;
            end
            if (rd_addr_vld[i] && rd_addr_rdy[i]) begin
                exp_q[i].push_back(sb[i][rd_addr[i]]);
            end
            exp_cnt[i]  = exp_q[i].size();
            exp_head[i] = (exp_cnt[i] != 0) ? exp_q[i][0] : '0;
        end
    end

    // ==============================
    // Checks
    // ==============================
    for (genvar i = 0; i < NUM_RDPORT; i++) begin : g_chk
        a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
            rd_dat_vld[i] |-> exp_cnt[i] != 0)
        else begin
            errors++;
            $display("Read port %0d shows valid data with no address pending", i);
        end

        a_latency: assert property (@(posedge clk) disable iff (!rst_n)
            rd_addr_vld[i] && rd_addr_rdy[i] |=> rd_dat_vld[i])
        else begin
            errors++;
            $display("Read port %0d data valid missing one cycle after address", i);
        end

        a_data: assert property (@(posedge clk) disable iff (!rst_n)
            rd_dat_vld[i] && rd_dat_rdy[i] && exp_cnt[i] != 0
            |-> (rd_dat[i] & keep[i]) == exp_head[i])
        else begin
            errors++;
            $display("FAIL %s port %0d expected %h actual %h", test_name, i,
                     $sampled(exp_head[i]), $sampled(rd_dat[i] & keep[i]));
        end

        // Held word and its valid must not move while the consumer stalls
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rd_dat_vld[i] && !rd_dat_rdy[i]
            |=> rd_dat_vld[i] && $stable(rd_dat[i] & keep[i]))
        else begin
            errors++;
            $display("Read port %0d data changed under back-pressure", i);
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        chk_idle |-> {rd_dat_vld, rd_addr_rdy, wr_full, wr_rdy} == 8'b0000_0011)
    else begin
        errors++;
        $display("FAIL %s expected %b actual %b", test_name, 8'b0000_0011,
                 $sampled({rd_dat_vld, rd_addr_rdy, wr_full, wr_rdy}));
    end

    a_unalloc: assert property (@(posedge clk) disable iff (!rst_n)
        chk_unalloc |-> !wr_rdy[1])
    else begin
        errors++;
        $display("FAIL %s expected wr_rdy 0 actual %b", test_name, $sampled(wr_rdy[1]));
    end

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        chk_full |-> wr_full[0] && !wr_rdy[0])
    else begin
        errors++;
        $display("FAIL %s expected full,rdy 10 actual %b%b", test_name,
                 $sampled(wr_full[0]), $sampled(wr_rdy[0]));
    end

    a_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        chk_not_full |-> !wr_full[0])
    else begin
        errors++;
        $display("FAIL %s expected full 0 actual %b", test_name, $sampled(wr_full[0]));
    end

    a_empty: assert property (@(posedge clk) disable iff (!rst_n)
        chk_empty |-> !rd_addr_rdy[0])
    else begin
        errors++;
        $display("FAIL %s expected rd_addr_rdy 0 actual %b", test_name,
                 $sampled(rd_addr_rdy[0]));
    end

    a_fill: assert property (@(posedge clk) disable iff (!rst_n)
        chk_empty && wr_vld[0] && wr_rdy[0] |=> rd_addr_rdy[0])
    else begin
        errors++;
        $display("FAIL %s expected rd_addr_rdy 1 actual 0", test_name);
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin : stimulus
        void'($urandom(32'hf8d5_f6c5));
        rst_n        = 1'b0;
        chk_idle     = 1'b0;
        chk_unalloc  = 1'b0;
        chk_full     = 1'b0;
        chk_not_full = 1'b0;
        chk_empty    = 1'b0;
        test_name    = "after_reset";

        // Pair 0 on banks 0-3 two lanes wide, pair 1 on banks 4-7 one lane
        cfg_wr_mask[0] = 8'h0f;
        cfg_wr_par[0]  = 3'd2;
        cfg_wr_mask[1] = 8'hf0;
        cfg_wr_par[1]  = 3'd1;
        cfg_rd_mask[0] = 8'h0f;
        cfg_rd_par[0]  = 3'd2;
        cfg_rd_mask[1] = 8'hf0;
        cfg_rd_par[1]  = 3'd1;
        for (int i = 0; i < NUM_RDPORT; i++) begin
            keep[i]    = lane_mask(cfg_rd_par[i]);
            wr_dat[i]  = '0;
            wr_addr[i] = '0;
            rd_addr[i] = '0;
        end
        wr_vld      = '0;
        rd_addr_vld = '0;
        rd_dat_rdy  = '1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        chk_idle = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        chk_idle       = 1'b0;
        chk_unalloc    = 1'b1;
        cfg_wr_mask[1] = '0;
        @(posedge clk);
        #1;
        chk_unalloc    = 1'b0;
        cfg_wr_mask[1] = 8'hf0;
        chk_idle       = 1'b1;
        @(posedge clk);
        #1;
        chk_idle = 1'b0;

        test_name = "round_trip";
        write_stream(0, 0, 32);
        read_stream(0, 0, 32);
        wait_drain();

        // Full window of 32 words outstanding, next address must stall
        test_name  = "full";
        write_stream(0, 32, 32);
        wr_addr[0] = 8'd64;
        chk_full   = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        chk_full = 1'b0;
        request_read(0, 8'd32);
        chk_not_full = 1'b1;
        @(posedge clk);
        #1;
        chk_not_full = 1'b0;
        read_stream(0, 33, 31);
        wait_drain();

        test_name  = "empty";
        rd_addr[0] = 8'd64;
        chk_empty  = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        write_word(0, 8'd64);
        chk_empty = 1'b0;
        read_stream(0, 64, 1);
        wait_drain();

        // Stay inside one bank group while the consumer stalls
        test_name = "back_pressure";
        write_stream(0, 65, 8);
        rd_dat_rdy[0] = 1'b0;
        fork
            read_stream(0, 65, 8);
            begin
                repeat (6) @(posedge clk);
                #1;
                rd_dat_rdy[0] = 1'b1;
            end
        join
        wait_drain();

        // Pair 1 crosses into bank 5 at 16 and bank 6 at 32
        test_name = "two_pairs";
        fork
            write_stream(0, 73, 32);
            read_stream(0, 73, 32);
            write_stream(1, 0, 40);
            read_stream(1, 0, 40);
        join
        wait_drain();

        $display("%0d reads checked, %0d errors", reads_checked, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stalled in %s, stopped after %0d cycles with %0d errors",
                 test_name, cycles, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== sim.f ====
source/glb_pkg.sv
source/glb_bank.sv
source/glb_port_map.sv
source/glb_ctrl.sv
source/glb_wr_route.sv
source/glb_rd_gather.sv
source/glb_top.sv
tests/glb_tb.sv

// ==== Bender.yml ====
package:
  name: glb

sources:
  - files:
      - source/glb_pkg.sv
      - source/glb_bank.sv
      - source/glb_port_map.sv
      - source/glb_ctrl.sv
      - source/glb_wr_route.sv
      - source/glb_rd_gather.sv
      - source/glb_top.sv
  - target: test
    files:
      - tests/glb_tb.sv
